// File: project.f
logic/misc_pkg.sv
logic/misc_regs.sv
logic/genio_bank.sv
logic/fsel_timer.sv
logic/reload_fsm.sv
logic/misc_periph.sv
dv/misc_periph_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the misc peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module misc_periph_tb -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vmisc_periph_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
	exit 0
fi
exit 1

// File: dv/misc_periph_tb.sv
// misc peripheral testbench
module misc_periph_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import misc_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam logic [31:0] SEED = 32'hfe9f;
	localparam logic [31:0] VERSION_EXP = 32'h0000_0000;
	localparam logic [23:0] KEY_VALUE = 24'hD0F1A5;
	// mux clock window position and width, counted from the write edge
	localparam int CLK_START = 4;
	localparam int CLK_WIDTH = 3;
	// strobe register, timer load, six counts to expiry, state update
	localparam int RELOAD_LAT = 9;
	// rough cycle budget per test
	localparam int TEST_CYCLES = 20 + 48 + 140 + 30 + 50 + 10;
	localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

	logic clk48m = 1'b0;
	logic rst;
	logic wr_stb_i;
	logic rd_stb_i;
	misc_reg_e addr_i;
	logic [31:0] wdata_i;
	logic [31:0] rdata_o;
	logic rd_valid_o;
	logic [7:0] btn_i;
	logic [29:0] genio_in_i;
	logic [8:0] led_o;
	logic trace_en_o;
	logic [29:0] genio_out_o;
	logic [29:0] genio_oe_o;
	logic fsel_d_o;
	logic fsel_c_o;
	logic programn_o;

	// register model
	logic [15:0] m_led;
	logic m_trace;
	logic m_fsel;
	logic [29:0] m_out;
	logic [29:0] m_oe;

	// pending checks, drained by the compare process
	string name_q[$];
	logic [31:0] exp_q[$];
	logic [31:0] act_q[$];
	event check_ev;
	string chk_name;
	logic [31:0] chk_exp;
	logic [31:0] chk_act;
	int chk_cnt = 0;
	int err_cnt = 0;
	int chk_base = 0;
	int err_base = 0;
	int test_cnt = 0;

	int i;
	int first_hi;
	int last_hi;
	int hi_cnt;
	int lo_prog;
	int fall_at;
	logic [31:0] r;
	misc_reg_e op;

	misc_periph i_dut (.*);

	always #(CLK_PERIOD / 2) clk48m = ~clk48m;

	// ------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------

	function automatic logic [31:0] expected_read(input misc_reg_e idx);
		case (idx)
			REG_LED: return {16'b0, m_led};
			REG_BTN: return {24'b0, ~btn_i};
			REG_SOC_VER: return VERSION_EXP;
			REG_FLASH_SEL: return {31'b0, m_fsel};
			REG_GENIO_IN: return {2'b0, genio_in_i};
			REG_GENIO_OUT: return {2'b0, m_out};
			REG_GENIO_OE: return {2'b0, m_oe};
			default: return 32'b0;
		endcase
	endfunction

	// pins 8..6 from bits 10..8, pins 5..0 from bits 5..0
	function automatic logic [8:0] led_pins(input logic [15:0] reg_val);
		return {reg_val[10:8], reg_val[5:0]};
	endfunction

	task automatic model_write(input misc_reg_e idx, input logic [31:0] d);
		case (idx)
			REG_LED: m_led = d[15:0];
			REG_SOC_VER: m_trace = d[0];
			REG_FLASH_SEL: m_fsel = d[0];
			REG_GENIO_OUT: m_out = d[29:0];
			REG_GENIO_OE: m_oe = d[29:0];
			REG_GENIO_W2S: m_out = m_out | d[29:0];
			REG_GENIO_W2C: m_out = m_out & ~d[29:0];
			default: ;
		endcase
	endtask

	// ------------------------------------------------------------------
	// bus access and checking
	// ------------------------------------------------------------------

	task automatic post_check(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
		-> check_ev;
	endtask

	task automatic bus_write(input misc_reg_e idx, input logic [31:0] d);
		@(posedge clk48m);
		wr_stb_i <= 1'b1;
		addr_i <= idx;
		wdata_i <= d;
		@(posedge clk48m);
		wr_stb_i <= 1'b0;
		model_write(idx, d);
	endtask

	// data is due one cycle after the strobe
	task automatic read_check(input string name, input misc_reg_e idx);
		logic [31:0] exp;
		exp = expected_read(idx);
		@(posedge clk48m);
		rd_stb_i <= 1'b1;
		addr_i <= idx;
		@(posedge clk48m);
		rd_stb_i <= 1'b0;
		@(negedge clk48m);
		post_check({name, " valid"}, 32'd1, {31'b0, rd_valid_o});
		post_check(name, exp, rdata_o);
	endtask

	task automatic end_test(input string name);
		#1;
		$display("test %s: %0d checks, %0d errors", name, chk_cnt - chk_base,
			err_cnt - err_base);
		chk_base = chk_cnt;
		err_base = err_cnt;
		test_cnt = test_cnt + 1;
	endtask

	initial begin
		forever begin
			@(check_ev);
			while (act_q.size() != 0) begin
				chk_name = name_q.pop_front();
				chk_exp = exp_q.pop_front();
				chk_act = act_q.pop_front();
				chk_cnt = chk_cnt + 1;
				assert (chk_act === chk_exp) else begin
					$display("** Error %s: expected %h, actual %h",
						chk_name, chk_exp, chk_act);
					err_cnt = err_cnt + 1;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: simulation did not finish within %0d ns", WATCHDOG_NS);
		$display("Errors found");
		$finish;
	end

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------

	initial begin
		void'($urandom(SEED));
		rst = 1'b1;
		wr_stb_i = 1'b0;
		rd_stb_i = 1'b0;
		addr_i = REG_LED;
		wdata_i = 32'b0;
		btn_i = 8'hff;
		genio_in_i = 30'b0;
		m_led = 16'b0;
		m_trace = 1'b0;
		m_fsel = 1'b0;
		m_out = 30'b0;
		m_oe = 30'b0;
		repeat (RESET_CYCLES) @(posedge clk48m);
		rst <= 1'b0;

		@(negedge clk48m);
		post_check("reset led", 32'b0, {23'b0, led_o});
		post_check("reset genio out", 32'b0, {2'b0, genio_out_o});
		post_check("reset genio oe", 32'b0, {2'b0, genio_oe_o});
		post_check("reset programn", 32'd1, {31'b0, programn_o});
		post_check("reset fsel clock", 32'b0, {31'b0, fsel_c_o});
		read_check("reset version", REG_SOC_VER);
		end_test("reset");

		for (i = 0; i < 8; i = i + 1) begin
			bus_write(REG_LED, $urandom());
			@(negedge clk48m);
			post_check("led pins", {23'b0, led_pins(m_led)}, {23'b0, led_o});
			read_check("led read", REG_LED);
		end
		end_test("led");

		for (i = 0; i < 16; i = i + 1) begin
			r = $urandom();
			case (r[1:0])
				2'd0: op = REG_GENIO_OUT;
				2'd1: op = REG_GENIO_OE;
				2'd2: op = REG_GENIO_W2S;
				default: op = REG_GENIO_W2C;
			endcase
			bus_write(op, $urandom());
			@(negedge clk48m);
			post_check("genio out pins", {2'b0, m_out}, {2'b0, genio_out_o});
			post_check("genio oe pins", {2'b0, m_oe}, {2'b0, genio_oe_o});
			read_check("genio out read", REG_GENIO_OUT);
		end
		r = $urandom();
		@(posedge clk48m);
		btn_i <= r[7:0];
		genio_in_i <= r[29:0];
		read_check("genio oe read", REG_GENIO_OE);
		read_check("button read", REG_BTN);
		read_check("genio in read", REG_GENIO_IN);
		read_check("write-only read", REG_GENIO_W2S);
		read_check("unknown index read", misc_reg_e'(5'd7));
		end_test("genio");

		// upper bits random but never the key
		r = $urandom();
		if (r[31:8] == KEY_VALUE) r[31:8] = ~r[31:8];
		bus_write(REG_FLASH_SEL, {r[31:8], 8'h01});
		first_hi = 0;
		last_hi = 0;
		hi_cnt = 0;
		lo_prog = 0;
		for (i = 1; i <= 20; i = i + 1) begin
			@(negedge clk48m);
			if (i == 1) post_check("fsel data", {31'b0, m_fsel}, {31'b0, fsel_d_o});
			if (fsel_c_o) begin
				hi_cnt = hi_cnt + 1;
				if (first_hi == 0) first_hi = i;
				last_hi = i;
			end
			if (!programn_o) lo_prog = lo_prog + 1;
		end
		post_check("fsel clock start", CLK_START, first_hi);
		post_check("fsel clock width", CLK_WIDTH, hi_cnt);
		post_check("fsel clock end", CLK_START + CLK_WIDTH - 1, last_hi);
		post_check("programn low cycles", 32'b0, lo_prog);
		end_test("flash select");

		bus_write(REG_FLASH_SEL, {KEY_VALUE, 8'h00});
		fall_at = 0;
		for (i = 1; i <= 30 && fall_at == 0; i = i + 1) begin
			@(negedge clk48m);
			if (!programn_o) fall_at = i;
		end
		assert (fall_at != 0) else begin
			$display("reload: programn never went low within 30 cycles");
			err_cnt = err_cnt + 1;
		end
		if (fall_at != 0) post_check("reload latency", RELOAD_LAT, fall_at);
		bus_write(REG_LED, $urandom());
		@(negedge clk48m);
		post_check("programn after led write", 32'b0, {31'b0, programn_o});
		bus_write(REG_GENIO_OUT, $urandom());
		@(negedge clk48m);
		post_check("programn after genio write", 32'b0, {31'b0, programn_o});
		bus_write(REG_FLASH_SEL, 32'h0000_0001);
		repeat (12) @(negedge clk48m);
		post_check("programn after fsel write", 32'b0, {31'b0, programn_o});
		end_test("reload");

		bus_write(REG_SOC_VER, 32'h0000_0001);
		@(negedge clk48m);
		post_check("trace set", {31'b0, m_trace}, {31'b0, trace_en_o});
		read_check("version read", REG_SOC_VER);
		bus_write(REG_SOC_VER, 32'h0000_0000);
		@(negedge clk48m);
		post_check("trace clear", {31'b0, m_trace}, {31'b0, trace_en_o});
		end_test("trace");

		$display("summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: logic/misc_periph.sv
// misc peripheral top
module misc_periph (
	input  logic                            clk48m,
	input  logic                            rst,
	input  logic                            wr_stb_i,
	input  logic                            rd_stb_i,
	input  misc_pkg::misc_reg_e             addr_i,
	input  logic [misc_pkg::DATA_W-1:0]     wdata_i,
	output logic [misc_pkg::DATA_W-1:0]     rdata_o,
	output logic                            rd_valid_o,
	input  logic [misc_pkg::BTN_W-1:0]      btn_i,
	input  logic [misc_pkg::GENIO_W-1:0]    genio_in_i,
	output logic [misc_pkg::LED_PIN_W-1:0]  led_o,
	output logic                            trace_en_o,
	output logic [misc_pkg::GENIO_W-1:0]    genio_out_o,
	output logic [misc_pkg::GENIO_W-1:0]    genio_oe_o,
	output logic                            fsel_d_o,
	output logic                            fsel_c_o,
	output logic                            programn_o
);
	import misc_pkg::*;

	logic genio_wr;
	misc_reg_e genio_op;
	logic [GENIO_W-1:0] genio_wdata;
	logic sel_stb;
	logic reload_req;
	logic timer_start;
	logic expire;

	misc_regs i_regs (
		.clk48m        (clk48m),
		.rst           (rst),
		.wr_stb_i      (wr_stb_i),
		.rd_stb_i      (rd_stb_i),
		.addr_i        (addr_i),
		.wdata_i       (wdata_i),
		.btn_i         (btn_i),
		.genio_in_i    (genio_in_i),
		.genio_out_i   (genio_out_o),
		.genio_oe_i    (genio_oe_o),
		.rdata_o       (rdata_o),
		.rd_valid_o    (rd_valid_o),
		.led_o         (led_o),
		.trace_en_o    (trace_en_o),
		.fsel_d_o      (fsel_d_o),
		.sel_stb_o     (sel_stb),
		.reload_req_o  (reload_req),
		.genio_wr_o    (genio_wr),
		.genio_op_o    (genio_op),
		.genio_wdata_o (genio_wdata)
	);

	genio_bank i_genio (
		.clk48m        (clk48m),
		.rst           (rst),
		.genio_wr_i    (genio_wr),
		.genio_op_i    (genio_op),
		.genio_wdata_i (genio_wdata),
		.genio_out_o   (genio_out_o),
		.genio_oe_o    (genio_oe_o)
	);

	// flash mux clock comes straight from the timer window
	fsel_timer i_timer (
		.clk48m   (clk48m),
		.rst      (rst),
		.start_i  (timer_start),
		.fsel_c_o (fsel_c_o),
		.expire_o (expire)
	);

	reload_fsm i_fsm (
		.clk48m        (clk48m),
		.rst           (rst),
		.sel_stb_i     (sel_stb),
		.reload_req_i  (reload_req),
		.expire_i      (expire),
		.timer_start_o (timer_start),
		.programn_o    (programn_o)
	);

endmodule

// File: logic/reload_fsm.sv
// flash select and reload sequencer
module reload_fsm (
	input  logic clk48m,
	input  logic rst,
	input  logic sel_stb_i,
	input  logic reload_req_i,
	input  logic expire_i,
	output logic timer_start_o,
	output logic programn_o
);
	import misc_pkg::*;

	reload_state_e state;
	logic req_q;

	// ------------------------------------------------------------------
	// state register
	// ------------------------------------------------------------------

	always_ff @(posedge clk48m) begin
		if (rst) begin
			state <= ST_IDLE;
			req_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (sel_stb_i) begin
						state <= ST_SETTLE;
						req_q <= reload_req_i;
					end
				end
				ST_SETTLE: begin
					if (sel_stb_i) begin
						// restart the delay, keep any earlier key
						req_q <= req_q | reload_req_i;
					end else if (expire_i) begin
						state <= req_q ? ST_RELOAD : ST_IDLE;
					end
				end
				// reload never leaves, only reset clears it
				ST_RELOAD: ;
				default: begin
					state <= ST_IDLE;
					req_q <= 1'b0;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------------

	assign timer_start_o = sel_stb_i && (state != ST_RELOAD);
	assign programn_o = (state != ST_RELOAD);

	a_reload_sticky: assert property (@(posedge clk48m) disable iff (rst)
		!programn_o |=> !programn_o)
		else $error("programn released without reset");

endmodule

// File: logic/fsel_timer.sv
// flash select settling timer
module fsel_timer (
	input  logic clk48m,
	input  logic rst,
	input  logic start_i,
	output logic fsel_c_o,
	output logic expire_o
);
	import misc_pkg::*;

	logic [FSEL_CNT_W-1:0] count;

	// ------------------------------------------------------------------
	// countdown
	// ------------------------------------------------------------------

	// a new start always reloads, even mid count
	always_ff @(posedge clk48m) begin
		if (rst) begin
			count <= '0;
		end else if (start_i) begin
			count <= FSEL_DELAY;
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// mux clock window in the middle of the delay
	assign fsel_c_o = (count <= FSEL_CLK_HI) && (count >= FSEL_CLK_LO);

	// last count before idle
	assign expire_o = (count == FSEL_CNT_W'(1));

	// a restart never lands on the expiry count
	a_start_not_expire: assert property (@(posedge clk48m) disable iff (rst)
		!(start_i && expire_o))
		else $error("timer start in the expiry cycle");

endmodule

// File: logic/genio_bank.sv
// general I/O register bank
module genio_bank (
	input  logic                          clk48m,
	input  logic                          rst,
	input  logic                          genio_wr_i,
	input  misc_pkg::misc_reg_e           genio_op_i,
	input  logic [misc_pkg::GENIO_W-1:0]  genio_wdata_i,
	output logic [misc_pkg::GENIO_W-1:0]  genio_out_o,
	output logic [misc_pkg::GENIO_W-1:0]  genio_oe_o
);
	import misc_pkg::*;

	// ------------------------------------------------------------------
	// output and enable registers
	// ------------------------------------------------------------------

	// all pins start as inputs driving low
	always_ff @(posedge clk48m) begin
		if (rst) begin
			genio_out_o <= '0;
			genio_oe_o <= '0;
		end else if (genio_wr_i) begin
			case (genio_op_i)
				REG_GENIO_OUT: begin
					genio_out_o <= genio_wdata_i;
				end
				REG_GENIO_OE: begin
					genio_oe_o <= genio_wdata_i;
				end
				// set and clear only touch bits written as one
				REG_GENIO_W2S: begin
					genio_out_o <= genio_out_o | genio_wdata_i;
				end
				REG_GENIO_W2C: begin
					genio_out_o <= genio_out_o & ~genio_wdata_i;
				end
				default: ;
			endcase
		end
	end

	// decode in the register block only forwards the four bank ops
	a_valid_op: assert property (@(posedge clk48m) disable iff (rst)
		genio_wr_i |-> (genio_op_i inside
			{REG_GENIO_OUT, REG_GENIO_OE, REG_GENIO_W2S, REG_GENIO_W2C}))
		else $error("general I/O write with op %0d", genio_op_i);

endmodule

// File: logic/misc_regs.sv
// misc register block
module misc_regs (
	input  logic                            clk48m,
	input  logic                            rst,
	input  logic                            wr_stb_i,
	input  logic                            rd_stb_i,
	input  misc_pkg::misc_reg_e             addr_i,
	input  logic [misc_pkg::DATA_W-1:0]     wdata_i,
	input  logic [misc_pkg::BTN_W-1:0]      btn_i,
	input  logic [misc_pkg::GENIO_W-1:0]    genio_in_i,
	input  logic [misc_pkg::GENIO_W-1:0]    genio_out_i,
	input  logic [misc_pkg::GENIO_W-1:0]    genio_oe_i,
	output logic [misc_pkg::DATA_W-1:0]     rdata_o,
	output logic                            rd_valid_o,
	output logic [misc_pkg::LED_PIN_W-1:0]  led_o,
	output logic                            trace_en_o,
	output logic                            fsel_d_o,
	output logic                            sel_stb_o,
	output logic                            reload_req_o,
	output logic                            genio_wr_o,
	output misc_pkg::misc_reg_e             genio_op_o,
	output logic [misc_pkg::GENIO_W-1:0]    genio_wdata_o
);
	import misc_pkg::*;

	logic [LED_REG_W-1:0] led_reg;
	logic [DATA_W-1:0] rd_mux;
	logic key_match;
	logic fsel_wr;

	// ------------------------------------------------------------------
	// write decode
	// ------------------------------------------------------------------

	assign fsel_wr = wr_stb_i && (addr_i == REG_FLASH_SEL);
	assign key_match = (wdata_i[DATA_W-1:KEY_LSB] == RELOAD_KEY);

	// general I/O writes go straight to the bank, it registers them
	assign genio_wr_o = wr_stb_i &&
		(addr_i inside {REG_GENIO_OUT, REG_GENIO_OE, REG_GENIO_W2S, REG_GENIO_W2C});
	assign genio_op_o = addr_i;
	assign genio_wdata_o = wdata_i[GENIO_W-1:0];

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_reg <= '0;
			trace_en_o <= 1'b0;
			fsel_d_o <= 1'b0;
			sel_stb_o <= 1'b0;
			reload_req_o <= 1'b0;
		end else begin
			// select pulse and key flag live for one cycle only
			sel_stb_o <= fsel_wr;
			reload_req_o <= fsel_wr && key_match;
			if (wr_stb_i) begin
				case (addr_i)
					REG_LED: led_reg <= wdata_i[LED_REG_W-1:0];
					REG_SOC_VER: trace_en_o <= wdata_i[0];
					REG_FLASH_SEL: fsel_d_o <= wdata_i[0];
					default: ;
				endcase
			end
		end
	end

	// pins 8..6 come from register bits 10..8
	assign led_o = {led_reg[10:8], led_reg[5:0]};

	// ------------------------------------------------------------------
	// read path
	// ------------------------------------------------------------------

	always_comb begin
		case (addr_i)
			REG_LED: rd_mux = {{(DATA_W-LED_REG_W){1'b0}}, led_reg};
			// buttons are active low on the board
			REG_BTN: rd_mux = {{(DATA_W-BTN_W){1'b0}}, ~btn_i};
			REG_SOC_VER: rd_mux = SOC_VERSION;
			REG_FLASH_SEL: rd_mux = {{(DATA_W-1){1'b0}}, fsel_d_o};
			REG_GENIO_IN: rd_mux = {{(DATA_W-GENIO_W){1'b0}}, genio_in_i};
			REG_GENIO_OUT: rd_mux = {{(DATA_W-GENIO_W){1'b0}}, genio_out_i};
			REG_GENIO_OE: rd_mux = {{(DATA_W-GENIO_W){1'b0}}, genio_oe_i};
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			rd_valid_o <= 1'b0;
		end else begin
			rd_valid_o <= rd_stb_i;
		end
	end

	always_ff @(posedge clk48m) begin
		if (rd_stb_i) begin
			rdata_o <= rd_mux;
		end
	end

	// master issues at most one strobe per cycle
	a_one_strobe: assert property (@(posedge clk48m) disable iff (rst)
		!(wr_stb_i && rd_stb_i))
		else $error("read and write strobe in the same cycle");

endmodule

// File: logic/misc_pkg.sv
// misc peripheral definitions
package misc_pkg;

	// ------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------

	localparam int DATA_W = 32;
	localparam int REG_IDX_W = 5;
	localparam int GENIO_W = 30;
	localparam int LED_REG_W = 16;
	localparam int LED_PIN_W = 9;
	localparam int BTN_W = 8;

	// ------------------------------------------------------------------
	// register map
	// ------------------------------------------------------------------

	// word index on the bus, gaps read as zero
	typedef enum logic [REG_IDX_W-1:0] {
		REG_LED       = 5'd0,
		REG_BTN       = 5'd1,
		REG_SOC_VER   = 5'd2,
		REG_FLASH_SEL = 5'd13,
		REG_GENIO_IN  = 5'd17,
		REG_GENIO_OUT = 5'd18,
		REG_GENIO_OE  = 5'd19,
		REG_GENIO_W2S = 5'd20,
		REG_GENIO_W2C = 5'd21
	} misc_reg_e;

	// hardware builds report zero here
	localparam logic [DATA_W-1:0] SOC_VERSION = 32'h0000_0000;

	// ------------------------------------------------------------------
	// flash select and reload
	// ------------------------------------------------------------------

	// key sits in the upper bits of the flash-select write
	localparam int KEY_LSB = 8;
	localparam logic [DATA_W-KEY_LSB-1:0] RELOAD_KEY = 24'hD0F1A5;

	localparam int FSEL_CNT_W = 3;
	localparam logic [FSEL_CNT_W-1:0] FSEL_DELAY = 3'd7;
	// mux clock is high while the count is inside this window
	localparam logic [FSEL_CNT_W-1:0] FSEL_CLK_HI = 3'd5;
	localparam logic [FSEL_CNT_W-1:0] FSEL_CLK_LO = 3'd3;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETTLE,
		ST_RELOAD
	} reload_state_e;

endpackage
